//--- src.f
+incdir+source
+incdir+tests
source/mbox_pkg.sv
source/mbox_push_if.sv
source/dram_simple_dual_port.sv
source/mbox_queue_ctrl.sv
source/mbox_apb_regs.sv
source/mbox_top.sv
tests/mbox_tb.sv

//--- Makefile
TOP := mbox_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

sim:
	verilator --binary --assert -j 0 -f src.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

//--- tests/mbox_model.svh
// reference model of the mailbox queue, included in the testbench module after the package import
`ifndef MBOX_MODEL_SVH
`define MBOX_MODEL_SVH

// accepted words with the head at index 0
logic [`MBOX_DATA_W-1:0] model_q [$];
logic model_ovf;
level_t model_thresh;
logic model_irq_en;

// state right after reset
function automatic void model_reset();
    model_q.delete();
    model_ovf = 1'b0;
    model_thresh = `MBOX_THRESH_RESET;
    model_irq_en = 1'b0;
endfunction

// write to DATA, dropped with overflow once all entries are taken
function automatic void model_push(input logic [`MBOX_DATA_W-1:0] word);
    if (model_q.size() < `MBOX_DEPTH)
    begin
        model_q.push_back(word);
    end
    else
    begin
        model_ovf = 1'b1;
    end
endfunction

// bit 0 clears overflow and bit 1 sets the irq enable
function automatic void model_ctrl_write(input logic [`MBOX_DATA_W-1:0] word);
    model_irq_en = word[1];
    if (word[0])
    begin
        model_ovf = 1'b0;
    end
endfunction

// next word expected on the stream, removed from the model
function automatic logic [`MBOX_DATA_W-1:0] model_pop();
    return model_q.pop_front();
endfunction

// STATUS layout is level, then empty, full and overflow at 8, 9, 10
function automatic logic [`MBOX_DATA_W-1:0] predict_status();
    logic [`MBOX_DATA_W-1:0] word;
    word = '0;
    word[`MBOX_LEVEL_W-1:0] = level_t'(model_q.size());
    word[8] = (model_q.size() == 0);
    word[9] = (model_q.size() == `MBOX_DEPTH);
    word[10] = model_ovf;
    return word;
endfunction

// almost full or sticky overflow, gated by the enable
function automatic logic predict_irq();
    return model_irq_en && ((level_t'(model_q.size()) >= model_thresh) || model_ovf);
endfunction

`endif

//--- tests/mbox_tb.sv
// mailbox testbench top that drives APB and the stream consumer and checks them against a queue model
`timescale 1ns/1ps
`include "mbox_consts.svh"

module mbox_tb;
    import mbox_pkg::*;

    `include "mbox_model.svh"

    // cycles any wait loop may spin
    localparam int wait_limit = 200;

    localparam logic [`MBOX_APB_ADDR_W-1:0] addr_data = `MBOX_APB_ADDR_W'(`MBOX_ADDR_DATA);
    localparam logic [`MBOX_APB_ADDR_W-1:0] addr_status = `MBOX_APB_ADDR_W'(`MBOX_ADDR_STATUS);
    localparam logic [`MBOX_APB_ADDR_W-1:0] addr_thresh = `MBOX_APB_ADDR_W'(`MBOX_ADDR_THRESH);
    localparam logic [`MBOX_APB_ADDR_W-1:0] addr_ctrl = `MBOX_APB_ADDR_W'(`MBOX_ADDR_CTRL);

    logic clk;
    logic rst_n;
    logic [`MBOX_APB_ADDR_W-1:0] paddr;
    logic psel;
    logic penable;
    logic pwrite;
    logic [`MBOX_DATA_W-1:0] pwdata;
    logic [`MBOX_DATA_W-1:0] prdata;
    logic pready;
    logic pslverr;
    logic m_valid;
    logic [`MBOX_DATA_W-1:0] m_data;
    logic m_ready;
    logic irq;

    // consumer takes words only while this is set
    logic drain_en;
    int n_checks;
    int n_errors;

    mbox_top mbox_top_inst (
        .clk(clk),
        .rst_n(rst_n),
        .paddr(paddr),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .m_valid(m_valid),
        .m_data(m_data),
        .m_ready(m_ready),
        .irq(irq)
    );

    // 10 ns clock
    always #5 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // check and bus tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(
        input string name,
        input logic [`MBOX_DATA_W-1:0] got,
        input logic [`MBOX_DATA_W-1:0] exp
    );
        n_checks++;
        assert (got === exp)
        else
        begin
            n_errors++;
            $display("** Error at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
        end
    endtask

    // one APB3 transfer with setup then access until pready
    task automatic apb_access(
        input logic [`MBOX_APB_ADDR_W-1:0] addr,
        input logic write,
        input logic [`MBOX_DATA_W-1:0] wdata,
        output logic [`MBOX_DATA_W-1:0] rdata,
        output logic err
    );
        int cycles;
        @(posedge clk);
        #1;
        paddr = addr;
        pwrite = write;
        pwdata = wdata;
        psel = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        cycles = 0;
        do
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        while (!pready && cycles < wait_limit);
        assert (pready)
        else
        begin
            n_errors++;
            $display("APB transfer to offset 0x%02h never completed", addr);
        end
        // one wait state means pready on the first sampled edge
        check_value("pready latency", 32'(cycles), 32'd1);
        rdata = prdata;
        err = pslverr;
        // hold the bus through the completion cycle
        @(posedge clk);
        #1;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(
        input logic [`MBOX_APB_ADDR_W-1:0] addr,
        input logic [`MBOX_DATA_W-1:0] wdata,
        input logic exp_err
    );
        logic [`MBOX_DATA_W-1:0] rdata;
        logic err;
        apb_access(addr, 1'b1, wdata, rdata, err);
        check_value("pslverr", 32'(err), 32'(exp_err));
    endtask

    task automatic apb_read(
        input logic [`MBOX_APB_ADDR_W-1:0] addr,
        input logic exp_err,
        output logic [`MBOX_DATA_W-1:0] rdata
    );
        logic err;
        apb_access(addr, 1'b0, '0, rdata, err);
        check_value("pslverr", 32'(err), 32'(exp_err));
    endtask

    // push one word and mirror it in the model
    task automatic write_data(input logic [`MBOX_DATA_W-1:0] word);
        apb_write(addr_data, word, 1'b0);
        model_push(word);
    endtask

    // only meaningful with the stream held
    task automatic read_status();
        logic [`MBOX_DATA_W-1:0] rdata;
        apb_read(addr_status, 1'b0, rdata);
        check_value("STATUS", rdata, predict_status());
        check_value("irq", 32'(irq), 32'(predict_irq()));
    endtask

    // let the consumer empty the queue, then hold the stream again
    task automatic wait_drained();
        int cycles;
        drain_en = 1'b1;
        cycles = 0;
        do
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        while ((model_q.size() != 0 || m_valid) && cycles < wait_limit);
        assert (model_q.size() == 0 && !m_valid)
        else
        begin
            n_errors++;
            $display("queue did not drain, %0d words still expected", model_q.size());
        end
        drain_en = 1'b0;
    endtask

    // irq sits up to two registers behind the flags
    // so at least two edges pass before it is compared
    task automatic settle_irq();
        int cycles;
        cycles = 0;
        while ((cycles < 2 || irq !== predict_irq()) && cycles < wait_limit)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        check_value("irq", 32'(irq), 32'(predict_irq()));
    endtask

    //////////////////////////////////////////////////////////////////////
    // stream consumer
    //////////////////////////////////////////////////////////////////////

    initial
    begin : consumer
        logic [`MBOX_DATA_W-1:0] expected;
        forever
        begin
            @(posedge clk);
            #1;
            // ready about three cycles in four
            m_ready = drain_en && ($urandom_range(0, 3) != 0);
            if (m_valid && m_ready)
            begin
                n_checks++;
                assert (model_q.size() != 0)
                else
                begin
                    n_errors++;
                    $display("stream delivered 0x%08h that was never queued", m_data);
                end
                if (model_q.size() != 0)
                begin
                    expected = model_pop();
                    check_value("m_data", m_data, expected);
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin : main
        logic [`MBOX_DATA_W-1:0] rdata;
        level_t thresh_val;
        int burst;
        clk = 1'b0;
        rst_n = 1'b0;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        m_ready = 1'b0;
        drain_en = 1'b0;
        n_checks = 0;
        n_errors = 0;
        model_reset();
        void'($urandom(58));
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // reset values
        check_value("irq", 32'(irq), 32'd0);
        check_value("m_valid", 32'(m_valid), 32'd0);
        read_status();
        apb_read(addr_thresh, 1'b0, rdata);
        check_value("THRESH", rdata, 32'(model_thresh));

        // random bursts drained under random ready
        for (int round = 0; round < 12; round++)
        begin
            burst = $urandom_range(1, 8);
            drain_en = 1'b1;
            repeat (burst) write_data($urandom());
            wait_drained();
        end

        // fill with the stream held and push once past full
        for (int i = 0; i < `MBOX_DEPTH + 1; i++)
        begin
            write_data(32'hA500_0000 | 32'(i));
            read_status();
        end
        apb_write(addr_ctrl, 32'h1, 1'b0);
        model_ctrl_write(32'h1);
        read_status();
        wait_drained();
        read_status();

        // irq from a random threshold
        thresh_val = level_t'($urandom_range(1, `MBOX_DEPTH));
        apb_write(addr_thresh, 32'(thresh_val), 1'b0);
        model_thresh = thresh_val;
        apb_write(addr_ctrl, 32'h2, 1'b0);
        model_ctrl_write(32'h2);
        settle_irq();
        for (int i = 0; i < int'(thresh_val); i++)
        begin
            write_data($urandom());
        end
        settle_irq();
        read_status();
        wait_drained();
        settle_irq();

        // irq from overflow with the threshold out of reach
        apb_write(addr_thresh, 32'h1F, 1'b0);
        model_thresh = 5'h1F;
        for (int i = 0; i < `MBOX_DEPTH + 1; i++)
        begin
            write_data($urandom());
        end
        settle_irq();
        wait_drained();
        // overflow is sticky past the drain
        settle_irq();
        apb_write(addr_ctrl, 32'h3, 1'b0);
        model_ctrl_write(32'h3);
        settle_irq();

        // slave errors leave everything as it was
        apb_read(addr_data, 1'b1, rdata);
        apb_write(8'h10, 32'hDEAD_BEEF, 1'b1);
        apb_write(8'h03, 32'h0000_0003, 1'b1);
        apb_read(8'h24, 1'b1, rdata);
        read_status();
        apb_read(addr_thresh, 1'b0, rdata);
        check_value("THRESH", rdata, 32'(model_thresh));
        apb_read(addr_ctrl, 1'b0, rdata);
        check_value("CTRL", rdata, 32'(model_irq_en) << 1);

        $display("checks: %0d  errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
        begin
            $display("NO ERRORS");
        end
        else
        begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- source/mbox_top.sv
// mailbox top level: APB3 slave in, valid/ready stream out, almost-full interrupt
`timescale 1ns/1ps
`include "mbox_consts.svh"

module mbox_top (
    input  logic clk,
    input  logic rst_n,

    // APB3 slave
    input  logic [`MBOX_APB_ADDR_W-1:0] paddr,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [`MBOX_DATA_W-1:0] pwdata,
    output logic [`MBOX_DATA_W-1:0] prdata,
    output logic pready,
    output logic pslverr,

    // stream to the consumer
    output logic m_valid,
    output logic [`MBOX_DATA_W-1:0] m_data,
    input  logic m_ready,

    output logic irq
);

    // push path and queue status
    mbox_push_if push_bus ();

    mbox_apb_regs regs_inst (
        .clk(clk),
        .rst_n(rst_n),
        .paddr(paddr),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .push_bus(push_bus.regs),
        .irq(irq)
    );

    mbox_queue_ctrl queue_inst (
        .clk(clk),
        .rst_n(rst_n),
        .push_bus(push_bus.queue),
        .m_valid(m_valid),
        .m_data(m_data),
        .m_ready(m_ready)
    );

endmodule

//--- source/mbox_apb_regs.sv
// APB3 slave for the mailbox: data push, status, threshold and control registers, irq
`timescale 1ns/1ps
`include "mbox_consts.svh"

module mbox_apb_regs (
    input  logic clk,
    input  logic rst_n,

    // APB3 slave
    input  logic [`MBOX_APB_ADDR_W-1:0] paddr,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [`MBOX_DATA_W-1:0] pwdata,
    output logic [`MBOX_DATA_W-1:0] prdata,
    output logic pready,
    output logic pslverr,

    // towards the queue controller
    mbox_push_if.regs push_bus,

    output logic irq
);
    import mbox_pkg::*;

    reg_addr_e reg_sel;
    level_t thresh;
    logic irq_en;
    logic ovf_flag;

    logic addr_ok;
    logic access_start;
    logic wr_ok;
    logic [`MBOX_DATA_W-1:0] rd_word;

    //////////////////////////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////////////////////////

    assign reg_sel = reg_addr_e'(paddr[3:0]);

    always_comb
    begin
        addr_ok = 1'b0;
        rd_word = '0;
        // upper address bits must be clear
        if (paddr[`MBOX_APB_ADDR_W-1:4] == '0)
        begin
            case (reg_sel)
                // write only
                REG_DATA: addr_ok = pwrite;
                REG_STATUS:
                begin
                    addr_ok = 1'b1;
                    rd_word[`MBOX_LEVEL_W-1:0] = push_bus.level;
                    rd_word[8]  = (push_bus.level == '0);
                    rd_word[9]  = push_bus.full;
                    rd_word[10] = ovf_flag;
                end
                REG_THRESH:
                begin
                    addr_ok = 1'b1;
                    rd_word[`MBOX_LEVEL_W-1:0] = thresh;
                end
                REG_CTRL:
                begin
                    addr_ok = 1'b1;
                    // bit 0 is write-1-to-clear, reads zero
                    rd_word[1] = irq_en;
                end
                default: addr_ok = 1'b0;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // handshake, one wait state
    //////////////////////////////////////////////////////////////////////

    // first access cycle only
    assign access_start = psel && penable && !pready;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pready  <= 1'b0;
            pslverr <= 1'b0;
        end
        else
        begin
            pready  <= access_start;
            pslverr <= access_start && !addr_ok;
        end
    end

    // read data sampled alongside pready
    always_ff @(posedge clk)
    begin
        if (access_start && !pwrite)
        begin
            prdata <= rd_word;
        end
    end

    // writes land in the completion cycle
    assign wr_ok = pready && pwrite && !pslverr;

    assign push_bus.push      = wr_ok && (reg_sel == REG_DATA);
    assign push_bus.push_data = pwdata;

    //////////////////////////////////////////////////////////////////////
    // config, sticky overflow, irq
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            thresh   <= `MBOX_THRESH_RESET;
            irq_en   <= 1'b0;
            ovf_flag <= 1'b0;
            irq      <= 1'b0;
        end
        else
        begin
            if (wr_ok && (reg_sel == REG_THRESH))
            begin
                thresh <= pwdata[`MBOX_LEVEL_W-1:0];
            end
            if (wr_ok && (reg_sel == REG_CTRL))
            begin
                irq_en <= pwdata[1];
            end
            // a new overflow beats a clear in the same cycle
            if (push_bus.overflow)
            begin
                ovf_flag <= 1'b1;
            end
            else if (wr_ok && (reg_sel == REG_CTRL) && pwdata[0])
            begin
                ovf_flag <= 1'b0;
            end
            irq <= irq_en && ((push_bus.level >= thresh) || ovf_flag);
        end
    end

    // completion only inside a live access phase
    a_pready_in_access : assert property (@(posedge clk) disable iff (!rst_n)
        pready |-> psel && penable);

endmodule

//--- source/mbox_queue_ctrl.sv
// queue controller holding pointers, fill level, overflow detect and the prefetching stream output for the mailbox top
`timescale 1ns/1ps
`include "mbox_consts.svh"

module mbox_queue_ctrl (
    input  logic clk,
    input  logic rst_n,

    // push requests in, status out
    mbox_push_if.queue push_bus,

    // stream output
    output logic m_valid,
    output logic [`MBOX_DATA_W-1:0] m_data,
    input  logic m_ready
);
    import mbox_pkg::*;

    localparam int ptr_w = $clog2(`MBOX_DEPTH);

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    level_t level;
    out_state_e state;
    out_state_e state_next;

    logic full;
    logic push_ok;
    logic pop;
    logic ren;

    //////////////////////////////////////////////////////////////////////
    // push side
    //////////////////////////////////////////////////////////////////////

    assign full    = (level == level_t'(`MBOX_DEPTH));
    // a push into a full queue is dropped here
    assign push_ok = push_bus.push && !full;

    assign push_bus.level    = level;
    assign push_bus.full     = full;
    assign push_bus.overflow = push_bus.push && full;

    // word on the port counts in level until it is taken
    assign pop = m_valid && m_ready;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end
        else
        begin
            if (push_ok)
            begin
                wr_ptr <= wr_ptr + ptr_w'(1);
            end
            // read pointer follows the fetches, not the pops
            if (ren)
            begin
                rd_ptr <= rd_ptr + ptr_w'(1);
            end
            case ({push_ok, pop})
                2'b10: level <= level + level_t'(1);
                2'b01: level <= level - level_t'(1);
                default: level <= level;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output stage
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        state_next = state;
        ren        = 1'b0;
        case (state)
            OUT_IDLE:
            begin
                // free stage fetches the head as soon as one is queued
                if (level != '0)
                begin
                    ren        = 1'b1;
                    state_next = OUT_FETCH;
                end
            end
            OUT_FETCH, OUT_HOLD:
            begin
                if (m_ready)
                begin
                    // refetch on the transfer cycle for one word per cycle
                    // taken word still counts in level so more than one is needed
                    if (level > level_t'(1))
                    begin
                        ren        = 1'b1;
                        state_next = OUT_FETCH;
                    end
                    else
                    begin
                        state_next = OUT_IDLE;
                    end
                end
                else
                begin
                    state_next = OUT_HOLD;
                end
            end
            default: state_next = OUT_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= OUT_IDLE;
        end
        else
        begin
            state <= state_next;
        end
    end

    assign m_valid = (state != OUT_IDLE);

    // output register of the RAM is the stream data register
    dram_simple_dual_port #(
        .mem_width(`MBOX_DATA_W),
        .mem_depth(`MBOX_DEPTH),
        .use_output_register(1'b1)
    ) ram_inst (
        .clk(clk),
        .rst_n(rst_n),
        .wen_a(push_ok),
        .addr_a(wr_ptr),
        .din_a(push_bus.push_data),
        .ren_b(ren),
        .addr_b(rd_ptr),
        .dout_b(m_data)
    );

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // level bounded by the queue size across any push/pop mix
    a_level_max : assert property (@(posedge clk) disable iff (!rst_n)
        level <= level_t'(`MBOX_DEPTH));

    // stalled word neither drops nor changes
    a_hold_stable : assert property (@(posedge clk) disable iff (!rst_n)
        m_valid && !m_ready |=> m_valid && $stable(m_data));

endmodule

//--- source/dram_simple_dual_port.sv
// simple dual-port distributed RAM, one write port and one read port, optional output register
`timescale 1ns/1ps

module dram_simple_dual_port #(
    parameter int mem_width = 24,
    parameter int mem_depth = 32,
    parameter bit use_output_register = 1'b1
) (
    input  logic clk,
    input  logic rst_n,

    // write port
    input  logic wen_a,
    input  logic [$clog2(mem_depth)-1:0] addr_a,
    input  logic [mem_width-1:0] din_a,

    // read port
    input  logic ren_b,
    input  logic [$clog2(mem_depth)-1:0] addr_b,
    output logic [mem_width-1:0] dout_b
);

    // storage, small enough to land in LUT RAM
    logic [mem_width-1:0] mem [mem_depth];

    //////////////////////////////////////////////////////////////////////
    // write port
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (wen_a)
        begin
            mem[addr_a] <= din_a;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read port
    //////////////////////////////////////////////////////////////////////

    generate
        if (use_output_register)
        begin : g_reg_out
            // latency 1, loads only when asked, keeps the word otherwise
            always_ff @(posedge clk or negedge rst_n)
            begin
                if (!rst_n)
                begin
                    dout_b <= '0;
                end
                else if (ren_b)
                begin
                    dout_b <= mem[addr_b];
                end
            end
        end
        else
        begin : g_comb_out
            // async read straight off the array
            assign dout_b = mem[addr_b];
        end
    endgenerate

endmodule

//--- source/mbox_push_if.sv
// push path and queue status between the APB register block and the queue controller
`timescale 1ns/1ps
`include "mbox_consts.svh"

interface mbox_push_if;
    import mbox_pkg::*;

    // one-cycle write request from the APB side
    logic push;
    logic [`MBOX_DATA_W-1:0] push_data;

    // queue state seen by the register block
    level_t level;
    logic full;
    // pulse, push hit a full queue and was dropped
    logic overflow;

    // register block side
    modport regs (
        output push,
        output push_data,
        input  level,
        input  full,
        input  overflow
    );

    // queue controller side
    modport queue (
        input  push,
        input  push_data,
        output level,
        output full,
        output overflow
    );

endinterface

//--- source/mbox_pkg.sv
// shared mailbox types, imported by the register block, the queue and the testbench
`include "mbox_consts.svh"

package mbox_pkg;

    //////////////////////////////////////////////////////////////////////
    // register offsets
    //////////////////////////////////////////////////////////////////////

    // values follow the byte offsets in the consts header
    typedef enum logic [3:0] {
        REG_DATA   = `MBOX_ADDR_DATA,
        REG_STATUS = `MBOX_ADDR_STATUS,
        REG_THRESH = `MBOX_ADDR_THRESH,
        REG_CTRL   = `MBOX_ADDR_CTRL
    } reg_addr_e;

    //////////////////////////////////////////////////////////////////////
    // stream output stage
    //////////////////////////////////////////////////////////////////////

    // idle: nothing loaded
    // fetch: word just read out of the RAM, first cycle on the port
    // hold: word stalled by the consumer for one cycle or more
    typedef enum logic [1:0] {
        OUT_IDLE  = 2'd0,
        OUT_FETCH = 2'd1,
        OUT_HOLD  = 2'd2
    } out_state_e;

    // fill level, 0 up to MBOX_DEPTH
    typedef logic [`MBOX_LEVEL_W-1:0] level_t;

endpackage

//--- source/mbox_consts.svh
// mailbox sizes and APB register offsets, included by RTL, package and testbench
`ifndef MBOX_CONSTS_SVH
`define MBOX_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// queue geometry
//////////////////////////////////////////////////////////////////////

// width of one queued word, also the APB data width
`define MBOX_DATA_W 32

// queue entries, power of two so the pointers wrap on their own
`define MBOX_DEPTH 16

// fill level, one bit over the RAM address so 16 fits
`define MBOX_LEVEL_W 5

//////////////////////////////////////////////////////////////////////
// APB register map
//////////////////////////////////////////////////////////////////////

// APB address bits seen by the slave
`define MBOX_APB_ADDR_W 8

// byte offsets of the four registers
`define MBOX_ADDR_DATA 4'h0
`define MBOX_ADDR_STATUS 4'h4
`define MBOX_ADDR_THRESH 4'h8
`define MBOX_ADDR_CTRL 4'hC

// almost-full threshold after reset
`define MBOX_THRESH_RESET 5'd12

`endif
